/* rtl/load_forward_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module load_forward_stage (
    input  wire logic                                 clock,
    input  wire logic                                 reset,

    // Load unit request, taken every cycle
    input  wire lsq_pkg::load_req_t                   load_req,

    // Store queue snapshot
    input  wire lsq_pkg::sq_entry_t [`SQ_SZ-1:0]      entries,
    input  wire lsq_pkg::sq_idx_t                     head,

    // Result, two cycles after the request
    output lsq_pkg::load_resp_t                       load_resp
);

    // Stage one request register
    lsq_pkg::load_req_t   req_q;

    // Stage two search results
    lsq_pkg::sq_idx_t     older_span;
    lsq_pkg::sq_idx_t     probe_slot;
    logic                 found;
    lsq_pkg::load_resp_e  search_kind;
    lsq_pkg::data_t       search_data;

    // Stage one
    always_ff @(posedge clock) begin
        req_q.addr <= load_req.addr;
        req_q.tail <= load_req.tail;
        if (reset) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= load_req.valid;
        end
    end

    // Stage two, age-ordered walk
    // Starts one slot before the load's tail and moves back toward head
    // Span of zero means no store was older at load dispatch
    always_comb begin
        older_span  = req_q.tail - head;
        probe_slot  = req_q.tail;
        found       = 1'b0;
        search_kind = lsq_pkg::resp_miss;
        search_data = '0;
        for (int i = 0; i < `SQ_SZ; i++) begin
            probe_slot = req_q.tail - lsq_pkg::sq_idx_t'(i + 1);
            if (!found && (i < older_span)) begin
                // Unknown address blocks everything older
                if (entries[probe_slot].busy && !entries[probe_slot].filled) begin
                    found       = 1'b1;
                    search_kind = lsq_pkg::resp_wait;
                end else if (entries[probe_slot].filled &&
                             (entries[probe_slot].addr == req_q.addr)) begin
                    // Youngest older match wins
                    found       = 1'b1;
                    search_kind = lsq_pkg::resp_forward;
                    search_data = entries[probe_slot].data;
                end
            end
        end
    end

    // Stage two result register
    always_ff @(posedge clock) begin
        load_resp.data <= search_data;
        if (reset) begin
            load_resp.valid <= 1'b0;
            load_resp.kind  <= lsq_pkg::resp_none;
        end else begin
            load_resp.valid <= req_q.valid;
            load_resp.kind  <= req_q.valid ? search_kind : lsq_pkg::resp_none;
        end
    end

endmodule

`default_nettype wire

/* rtl/lsq_cfg.svh */
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// Store queue depth in entries
`define SQ_SZ 8

// Bits to name one queue slot
`define SQ_IDX_BITS 3

// Bits for an occupancy count, 0 up to SQ_SZ inclusive
`define SQ_CNT_BITS 4

// Superscalar width, max stores dispatched or retired per cycle
`define SQ_N 2

// Bits for a per-cycle count, 0 up to SQ_N inclusive
`define SQ_N_BITS 2

// Address and data word width
`define XLEN 32

`endif

/* rtl/lsq_pkg.sv */
`default_nettype none

`include "lsq_cfg.svh"

package lsq_pkg;

    // Full words only, no byte enables
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [`XLEN-1:0] data_t;

    // Slot number inside the circular store queue
    typedef logic [`SQ_IDX_BITS-1:0] sq_idx_t;

    // One store queue slot
    // busy set at dispatch, filled set once the store unit delivers addr and data
    typedef struct packed {
        logic  busy;
        logic  filled;
        addr_t addr;
        data_t data;
    } sq_entry_t;

    // Store unit result, written into the slot named by idx
    typedef struct packed {
        logic    valid;
        sq_idx_t idx;
        addr_t   addr;
        data_t   data;
    } sq_fill_t;

    // Load lookup request
    // tail is the queue tail seen at load dispatch, older stores sit in [head, tail)
    typedef struct packed {
        logic    valid;
        addr_t   addr;
        sq_idx_t tail;
    } load_req_t;

    // Outcome of the older-store search
    typedef enum logic [1:0] {
        resp_none    = 2'd0,
        resp_forward = 2'd1,
        resp_miss    = 2'd2,
        resp_wait    = 2'd3
    } load_resp_e;

    // Result handed back to the load unit
    typedef struct packed {
        logic       valid;
        load_resp_e kind;
        data_t      data;
    } load_resp_t;

    // Retired store on its way to the data cache
    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;
    } commit_write_t;

endpackage

`default_nettype wire

/* rtl/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_top (
    input  wire logic                                 clock,
    input  wire logic                                 reset,

    // Dispatch
    input  wire logic [`SQ_N_BITS-1:0]                stores_dispatching,
    output logic [`SQ_N_BITS-1:0]                     spots,
    output lsq_pkg::sq_idx_t                          tail,

    // Store unit
    input  wire lsq_pkg::sq_fill_t                    fill,

    // Load unit
    input  wire lsq_pkg::load_req_t                   load_req,
    output lsq_pkg::load_resp_t                       load_resp,

    // Retire and cache write port
    input  wire logic [`SQ_N_BITS-1:0]                stores_retiring,
    output lsq_pkg::commit_write_t [`SQ_N-1:0]        commit_writes
);

    // Snapshot from the queue to the load search
    lsq_pkg::sq_entry_t [`SQ_SZ-1:0]  sq_entries;
    lsq_pkg::sq_idx_t                 sq_head;

    // Circular store queue
    store_queue i_store_queue (
        .clock              (clock),
        .reset              (reset),
        .stores_dispatching (stores_dispatching),
        .spots              (spots),
        .tail               (tail),
        .fill               (fill),
        .stores_retiring    (stores_retiring),
        .commit_writes      (commit_writes),
        .head               (sq_head),
        .entries            (sq_entries)
    );

    // Two-stage forwarding search
    load_forward_stage i_load_forward_stage (
        .clock     (clock),
        .reset     (reset),
        .load_req  (load_req),
        .entries   (sq_entries),
        .head      (sq_head),
        .load_resp (load_resp)
    );

endmodule

`default_nettype wire

/* rtl/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module store_queue (
    input  wire logic                                     clock,
    input  wire logic                                     reset,

    // Dispatch side
    input  wire logic [`SQ_N_BITS-1:0]                    stores_dispatching,
    output logic [`SQ_N_BITS-1:0]                         spots,
    output lsq_pkg::sq_idx_t                              tail,

    // Store unit side
    input  wire lsq_pkg::sq_fill_t                        fill,

    // Retire side
    input  wire logic [`SQ_N_BITS-1:0]                    stores_retiring,
    output lsq_pkg::commit_write_t [`SQ_N-1:0]            commit_writes,

    // Snapshot for the load search
    output lsq_pkg::sq_idx_t                              head,
    output lsq_pkg::sq_entry_t [`SQ_SZ-1:0]               entries
);

    // Pointer and occupancy state
    lsq_pkg::sq_idx_t          tail_q;
    lsq_pkg::sq_idx_t          head_q;
    logic [`SQ_CNT_BITS-1:0]   occupancy;

    // Next-state values
    lsq_pkg::sq_idx_t          tail_next;
    lsq_pkg::sq_idx_t          head_next;
    logic [`SQ_CNT_BITS-1:0]   occupancy_next;
    logic [`SQ_CNT_BITS-1:0]   free_count;

    // Slots touched this cycle, one per scalar lane
    lsq_pkg::sq_idx_t [`SQ_N-1:0] dispatch_slot;
    lsq_pkg::sq_idx_t [`SQ_N-1:0] retire_slot;

    // Entry storage
    lsq_pkg::sq_entry_t [`SQ_SZ-1:0] entries_q;

    // Pointer math
    // Index width matches the depth, so plain addition wraps modulo SQ_SZ
    always_comb begin
        tail_next = tail_q + lsq_pkg::sq_idx_t'(stores_dispatching);
        head_next = head_q + lsq_pkg::sq_idx_t'(stores_retiring);
        occupancy_next = occupancy
                       + `SQ_CNT_BITS'(stores_dispatching)
                       - `SQ_CNT_BITS'(stores_retiring);
    end

    // Lane slots, counted from tail for dispatch and from head for retire
    always_comb begin
        for (int i = 0; i < `SQ_N; i++) begin
            dispatch_slot[i] = tail_q + lsq_pkg::sq_idx_t'(i);
            retire_slot[i]   = head_q + lsq_pkg::sq_idx_t'(i);
        end
    end

    // Free spots offered to dispatch, capped at the scalar width
    always_comb begin
        free_count = `SQ_CNT_BITS'(`SQ_SZ) - occupancy;
        if (free_count < `SQ_CNT_BITS'(`SQ_N)) begin
            spots = `SQ_N_BITS'(free_count);
        end else begin
            spots = `SQ_N_BITS'(`SQ_N);
        end
    end

    // Pointers and count
    always_ff @(posedge clock) begin
        if (reset) begin
            tail_q    <= '0;
            head_q    <= '0;
            occupancy <= '0;
        end else begin
            tail_q    <= tail_next;
            head_q    <= head_next;
            occupancy <= occupancy_next;
        end
    end

    // Entry array update
    // Fill, retire and dispatch never hit the same slot in one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            entries_q <= '0;
        end else begin
            // Store unit writes addr and data into an allocated slot
            if (fill.valid) begin
                entries_q[fill.idx].addr   <= fill.addr;
                entries_q[fill.idx].data   <= fill.data;
                entries_q[fill.idx].filled <= 1'b1;
            end

            // Retired slots are released
            for (int i = 0; i < `SQ_N; i++) begin
                if (i < stores_retiring) begin
                    entries_q[retire_slot[i]].busy   <= 1'b0;
                    entries_q[retire_slot[i]].filled <= 1'b0;
                end
            end

            // Newly dispatched stores, address still unknown
            for (int i = 0; i < `SQ_N; i++) begin
                if (i < stores_dispatching) begin
                    entries_q[dispatch_slot[i]].busy   <= 1'b1;
                    entries_q[dispatch_slot[i]].filled <= 1'b0;
                end
            end
        end
    end

    // Commit-write register
    // Oldest retired store lands in lane 0, valid for one cycle
    always_ff @(posedge clock) begin
        for (int i = 0; i < `SQ_N; i++) begin
            commit_writes[i].addr <= entries_q[retire_slot[i]].addr;
            commit_writes[i].data <= entries_q[retire_slot[i]].data;
        end
        if (reset) begin
            for (int i = 0; i < `SQ_N; i++) begin
                commit_writes[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `SQ_N; i++) begin
                commit_writes[i].valid <= (i < stores_retiring);
            end
        end
    end

    // Outputs
    assign tail    = tail_q;
    assign head    = head_q;
    assign entries = entries_q;

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/lsq_pkg.sv
rtl/store_queue.sv
rtl/load_forward_stage.sv
rtl/lsq_top.sv
verification/lsq_assert.sv
verification/lsq_tb.sv

/* verification/lsq_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_assert (
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire logic [`SQ_CNT_BITS-1:0]          occupancy,
    input  wire logic [`SQ_N_BITS-1:0]            stores_dispatching,
    input  wire logic [`SQ_N_BITS-1:0]            spots,
    input  wire logic [`SQ_N_BITS-1:0]            stores_retiring,
    input  wire lsq_pkg::sq_idx_t                 head,
    input  wire lsq_pkg::sq_entry_t [`SQ_SZ-1:0]  entries
);

    // Number of failed properties, summed into the final report
    int failure_count = 0;

    // Queue never holds more than its depth
    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        occupancy <= `SQ_SZ)
    else begin
        $error("store queue occupancy %0d above depth", occupancy);
        failure_count++;
    end

    // Dispatch stays within the offered spots
    dispatch_bound: assert property (@(posedge clock) disable iff (reset)
        stores_dispatching <= spots)
    else begin
        $error("dispatch of %0d with only %0d spots", stores_dispatching, spots);
        failure_count++;
    end

    // Every retiring lane takes a head entry whose address and data are known
    for (genvar lane = 0; lane < `SQ_N; lane++) begin : g_retire_lane
        lsq_pkg::sq_idx_t slot;

        assign slot = head + lsq_pkg::sq_idx_t'(lane);

        retire_filled: assert property (@(posedge clock) disable iff (reset)
            (stores_retiring > lane) |-> entries[slot].filled)
        else begin
            $error("retire of unfilled entry %0d", slot);
            failure_count++;
        end
    end

endmodule

bind store_queue lsq_assert i_lsq_assert (
    .clock              (clock),
    .reset              (reset),
    .occupancy          (occupancy),
    .stores_dispatching (stores_dispatching),
    .spots              (spots),
    .stores_retiring    (stores_retiring),
    .head               (head_q),
    .entries            (entries_q)
);

`default_nettype wire

/* verification/lsq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsq_cfg.svh"

module lsq_tb;

    // One table row per clock cycle
    typedef struct packed {
        logic [2:0]              test;
        logic [`SQ_N_BITS-1:0]   disp;
        logic                    fill_v;
        lsq_pkg::sq_idx_t        fill_idx;
        lsq_pkg::addr_t          fill_addr;
        logic                    load_v;
        lsq_pkg::addr_t          load_addr;
        lsq_pkg::sq_idx_t        load_tail;
        logic [`SQ_N_BITS-1:0]   ret;
        logic [`SQ_N_BITS-1:0]   exp_spots;
        lsq_pkg::sq_idx_t        exp_tail;
        lsq_pkg::load_resp_e     exp_kind;
        lsq_pkg::sq_idx_t        exp_idx;
    } step_t;

    localparam lsq_pkg::load_resp_e r_none = lsq_pkg::resp_none;
    localparam lsq_pkg::load_resp_e r_fwd  = lsq_pkg::resp_forward;
    localparam lsq_pkg::load_resp_e r_miss = lsq_pkg::resp_miss;
    localparam lsq_pkg::load_resp_e r_wait = lsq_pkg::resp_wait;

    // DUT ports
    logic                                   clock;
    logic                                   reset;
    logic [`SQ_N_BITS-1:0]                  stores_dispatching;
    logic [`SQ_N_BITS-1:0]                  spots;
    lsq_pkg::sq_idx_t                       tail;
    lsq_pkg::sq_fill_t                      fill;
    lsq_pkg::load_req_t                     load_req;
    lsq_pkg::load_resp_t                    load_resp;
    logic [`SQ_N_BITS-1:0]                  stores_retiring;
    lsq_pkg::commit_write_t [`SQ_N-1:0]     commit_writes;

    // Step table and scoreboard of what each slot was filled with
    step_t                                  steps[$];
    lsq_pkg::addr_t                         sb_addr [`SQ_SZ];
    lsq_pkg::data_t                         sb_data [`SQ_SZ];
    int                                     model_head;

    // Expected outputs, one cycle out for commits and two for loads
    lsq_pkg::commit_write_t [`SQ_N-1:0]     cw_exp;
    lsq_pkg::load_resp_t                    resp_exp_1;
    lsq_pkg::load_resp_t                    resp_exp_2;

    int check_count;
    int error_count;
    int test_checks;
    int test_errors;
    int test_total;
    string test_names [6] = '{"", "reset and fill", "forward", "miss",
                              "wait and replay", "retire and wrap"};

    lsq_top i_lsq_top (
        .clock              (clock),
        .reset              (reset),
        .stores_dispatching (stores_dispatching),
        .spots              (spots),
        .tail               (tail),
        .fill               (fill),
        .load_req           (load_req),
        .load_resp          (load_resp),
        .stores_retiring    (stores_retiring),
        .commit_writes      (commit_writes)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    task automatic add_step(input int test, input int disp, input int fv, input int fidx,
                            input int faddr, input int lv, input int laddr, input int ltail,
                            input int ret, input int es, input int et,
                            input lsq_pkg::load_resp_e ek, input int ei);
        step_t s;
        s.test      = 3'(test);
        s.disp      = `SQ_N_BITS'(disp);
        s.fill_v    = 1'(fv);
        s.fill_idx  = lsq_pkg::sq_idx_t'(fidx);
        s.fill_addr = lsq_pkg::addr_t'(faddr);
        s.load_v    = 1'(lv);
        s.load_addr = lsq_pkg::addr_t'(laddr);
        s.load_tail = lsq_pkg::sq_idx_t'(ltail);
        s.ret       = `SQ_N_BITS'(ret);
        s.exp_spots = `SQ_N_BITS'(es);
        s.exp_tail  = lsq_pkg::sq_idx_t'(et);
        s.exp_kind  = ek;
        s.exp_idx   = lsq_pkg::sq_idx_t'(ei);
        steps.push_back(s);
    endtask

    task automatic build_table();
        // test disp | fill v idx addr | load v addr tail | ret | spots tail kind idx
        add_step(1, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 0, r_none, 0);
        add_step(1, 2, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 0, r_none, 0);
        add_step(1, 2, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 2, r_none, 0);
        add_step(1, 2, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 4, r_none, 0);
        add_step(1, 2, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 6, r_none, 0);
        // Full queue, tail back at slot 0
        add_step(1, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(1, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(2, 0, 1, 0, 'h100, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(2, 0, 1, 1, 'h200, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(2, 0, 1, 2, 'h100, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(2, 0, 1, 3, 'h300, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        // Slots 0 and 2 both match, the younger slot 2 wins
        add_step(2, 0, 1, 4, 'h700, 1, 'h100, 4, 0, 0, 0, r_fwd,  2);
        add_step(2, 0, 1, 5, 'h100, 1, 'h200, 4, 0, 0, 0, r_fwd,  1);
        add_step(2, 0, 1, 6, 'h400, 1, 'h100, 2, 0, 0, 0, r_fwd,  0);
        add_step(2, 0, 1, 7, 'h500, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(2, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        // Matches in slots 6 and 7 are younger than the load
        add_step(3, 0, 0, 0, 'h000, 1, 'h999, 4, 0, 0, 0, r_miss, 0);
        add_step(3, 0, 0, 0, 'h000, 1, 'h400, 4, 0, 0, 0, r_miss, 0);
        add_step(3, 0, 0, 0, 'h000, 1, 'h500, 7, 0, 0, 0, r_miss, 0);
        add_step(3, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        add_step(3, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 0, 0, r_none, 0);
        // Free four slots, then reallocate 0 and 1 without data
        add_step(4, 0, 0, 0, 'h000, 0, 'h000, 0, 2, 0, 0, r_none, 0);
        add_step(4, 0, 0, 0, 'h000, 0, 'h000, 0, 2, 2, 0, r_none, 0);
        add_step(4, 2, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 0, r_none, 0);
        add_step(4, 0, 0, 0, 'h000, 1, 'h100, 2, 0, 2, 2, r_wait, 0);
        add_step(4, 0, 1, 1, 'h100, 0, 'h000, 0, 0, 2, 2, r_none, 0);
        add_step(4, 0, 0, 0, 'h000, 1, 'h100, 2, 0, 2, 2, r_fwd,  1);
        add_step(4, 0, 0, 0, 'h000, 1, 'h500, 2, 0, 2, 2, r_wait, 0);
        add_step(4, 0, 1, 0, 'h600, 0, 'h000, 0, 0, 2, 2, r_none, 0);
        // Walk wraps past slot 0 to find slot 7
        add_step(4, 0, 0, 0, 'h000, 1, 'h500, 2, 0, 2, 2, r_fwd,  7);
        add_step(4, 0, 0, 0, 'h000, 1, 'h999, 2, 0, 2, 2, r_miss, 0);
        add_step(4, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 2, r_none, 0);
        add_step(4, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 2, r_none, 0);
        add_step(5, 0, 0, 0, 'h000, 0, 'h000, 0, 2, 2, 2, r_none, 0);
        add_step(5, 2, 0, 0, 'h000, 0, 'h000, 0, 2, 2, 2, r_none, 0);
        add_step(5, 0, 1, 2, 'h800, 0, 'h000, 0, 2, 2, 4, r_none, 0);
        add_step(5, 2, 1, 3, 'h900, 0, 'h000, 0, 0, 2, 4, r_none, 0);
        add_step(5, 0, 1, 4, 'hA00, 0, 'h000, 0, 2, 2, 6, r_none, 0);
        add_step(5, 2, 1, 5, 'hB00, 0, 'h000, 0, 0, 2, 6, r_none, 0);
        add_step(5, 0, 1, 6, 'hC00, 0, 'h000, 0, 2, 2, 0, r_none, 0);
        add_step(5, 2, 1, 7, 'hD00, 0, 'h000, 0, 0, 2, 0, r_none, 0);
        add_step(5, 0, 1, 0, 'hE00, 0, 'h000, 0, 2, 2, 2, r_none, 0);
        add_step(5, 0, 1, 1, 'hF00, 1, 'hE00, 2, 0, 2, 2, r_fwd,  0);
        add_step(5, 0, 0, 0, 'h000, 0, 'h000, 0, 2, 2, 2, r_none, 0);
        add_step(5, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 2, r_none, 0);
        add_step(5, 0, 0, 0, 'h000, 0, 'h000, 0, 0, 2, 2, r_none, 0);
    endtask

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_count++;
        test_checks++;
        assert (got === expected) else begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // Outputs of this cycle against the row and the pending expectations
    task automatic check_outputs(input step_t s);
        compare_value("spots", spots, s.exp_spots);
        compare_value("tail", tail, s.exp_tail);
        for (int lane = 0; lane < `SQ_N; lane++) begin
            compare_value($sformatf("commit_writes[%0d].valid", lane),
                          commit_writes[lane].valid, cw_exp[lane].valid);
            if (cw_exp[lane].valid) begin
                compare_value($sformatf("commit_writes[%0d].addr", lane),
                              commit_writes[lane].addr, cw_exp[lane].addr);
                compare_value($sformatf("commit_writes[%0d].data", lane),
                              commit_writes[lane].data, cw_exp[lane].data);
            end
        end
        compare_value("load_resp.valid", load_resp.valid, resp_exp_2.valid);
        if (resp_exp_2.valid) begin
            compare_value("load_resp.kind", load_resp.kind, resp_exp_2.kind);
            if (resp_exp_2.kind == r_fwd) begin
                compare_value("load_resp.data", load_resp.data, resp_exp_2.data);
            end
        end
    endtask

    // Drive one row and update the model
    task automatic apply_step(input step_t s);
        lsq_pkg::data_t word;
        int             slot;
        word = '0;
        if (s.fill_v) begin
            word = $urandom;
        end
        stores_dispatching = s.disp;
        fill.valid         = s.fill_v;
        fill.idx           = s.fill_idx;
        fill.addr          = s.fill_addr;
        fill.data          = word;
        load_req.valid     = s.load_v;
        load_req.addr      = s.load_addr;
        load_req.tail      = s.load_tail;
        stores_retiring    = s.ret;
        if (s.fill_v) begin
            sb_addr[s.fill_idx] = s.fill_addr;
            sb_data[s.fill_idx] = word;
        end
        // A fill in this row is already visible to this row's load
        resp_exp_2       = resp_exp_1;
        resp_exp_1.valid = s.load_v;
        resp_exp_1.kind  = s.load_v ? s.exp_kind : r_none;
        resp_exp_1.data  = (s.load_v && s.exp_kind == r_fwd) ? sb_data[s.exp_idx] : '0;
        // Oldest retired entry expected in lane 0
        for (int lane = 0; lane < `SQ_N; lane++) begin
            slot = (model_head + lane) % `SQ_SZ;
            cw_exp[lane].valid = (lane < s.ret);
            cw_exp[lane].addr  = sb_addr[slot];
            cw_exp[lane].data  = sb_data[slot];
        end
        model_head = (model_head + s.ret) % `SQ_SZ;
    endtask

    task automatic report_test(input int test);
        $display("Test %0d (%s): %0d checks, %0d errors",
                 test, test_names[test], test_checks, test_errors);
        test_total++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int assert_failures;
        void'($urandom(32'h9713e1e5));
        reset              = 1'b1;
        stores_dispatching = '0;
        fill               = '0;
        load_req           = '0;
        stores_retiring    = '0;
        sb_addr            = '{default: '0};
        sb_data            = '{default: '0};
        cw_exp             = '0;
        resp_exp_1         = '0;
        resp_exp_2         = '0;
        model_head         = 0;
        check_count        = 0;
        error_count        = 0;
        test_checks        = 0;
        test_errors        = 0;
        test_total         = 0;
        build_table();
        repeat (16) @(posedge clock);
        #1 reset = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clock);
            #1;
            check_outputs(steps[i]);
            apply_step(steps[i]);
            // Each test ends in idle rows, so its delayed checks are done here
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                report_test(steps[i].test);
            end
        end
        assert_failures = i_lsq_top.i_store_queue.i_lsq_assert.failure_count;
        $display("Done: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_total, check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, sized from the table length plus reset and drain margin
    initial begin
        #1;
        #((steps.size() + 40) * 100);
        $display("Timeout: the step table did not complete before the watchdog limit");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
